// File: include/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// tile shape
`define CONV_LANES       4   // 8-bit pixels per feature word
`define CONV_OCH         4   // output channels in parallel
`define CONV_PIX_W       8
`define CONV_WORD_W     32

// buffer sizes
`define CONV_FMAP_DEPTH 256
`define CONV_WMAP_DEPTH 256
`define CONV_BUF_AW      8

// arithmetic widths
`define CONV_ACC_W      24   // 16 plus 8 headroom
`define CONV_BIAS_W     16
`define CONV_TAIL_W     16
`define CONV_RANK_W      5

// host bus and geometry
`define CONV_WB_AW      12
`define CONV_DIM_W       5   // ix, iy up to 16

`endif

// File: hw/conv_pkg.sv
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

    typedef logic signed [`CONV_PIX_W-1:0] sbyte_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // one weight word, decoded by cfg.mode
    // channel c owns byte c in both views
    typedef union packed {
        sbyte_t [`CONV_OCH-1:0]                     w8;  // mode 0
        logic [`CONV_OCH-1:0][`CONV_LANES-1:0][1:0] w2;  // mode 1 ternary
    } weight_word_u;

    // ternary code 01 means +1 and 11 means -1, the others add nothing

    typedef struct packed {
        logic [`CONV_DIM_W-1:0]                  ix;
        logic [`CONV_DIM_W-1:0]                  iy;
        logic [1:0]                              k;          // 1..3
        logic [1:0]                              s;          // 1 or 2
        logic [2:0]                              nif_words;  // 1..4
        logic                                    mode;
        logic [`CONV_OCH-1:0][`CONV_BIAS_W-1:0]  bias;
        logic [`CONV_OCH-1:0][`CONV_TAIL_W-1:0]  tail;
        logic [`CONV_OCH-1:0][`CONV_RANK_W-1:0]  rank;
    } conv_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic [`CONV_BUF_AW-1:0] f_adr;
        logic [`CONV_BUF_AW-1:0] w_adr;
        logic [1:0]              lane;   // feature lane, mode 0 only
        logic                    first;  // first term of an output pixel
        logic                    last;
    } rd_req_t;

    typedef struct packed {
        logic                   valid;
        sbyte_t [`CONV_OCH-1:0] data;
    } conv_out_t;

endpackage

`default_nettype wire

// File: hw/conv_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_cfg_regs import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`CONV_WB_AW-1:0]  wb_adr,
    input  logic [`CONV_WORD_W-1:0] wb_dat_w,
    output logic [`CONV_WORD_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    output logic                    buf_we_f,
    output logic                    buf_we_w,
    output logic [`CONV_BUF_AW-1:0] buf_adr,
    output logic [`CONV_WORD_W-1:0] buf_dat,
    output conv_cfg_t               cfg,
    output logic                    start,
    input  logic                    tile_done,
    input  logic                    out_valid
);

    logic                       acc_cyc;    // first cycle of a bus access
    logic                       wr_ok;
    logic [`CONV_WORD_W-1:0]    rd_mux;
    logic                       sh;
    logic [`CONV_DIM_W-1:0]     ox_last;
    logic [`CONV_DIM_W-1:0]     oy_last;
    logic [2*`CONV_DIM_W-1:0]   n_out;
    logic [2*`CONV_DIM_W-1:0]   pending;    // results not yet seen on out_valid
    logic                       busy;
    logic                       done;
    logic                       walk_done;

    assign acc_cyc  = wb_cyc && wb_stb && !wb_ack;
    assign wr_ok    = acc_cyc && wb_we && !busy;   // writes dropped while busy
    assign buf_we_f = wr_ok && (wb_adr[11:8] == 4'h0);
    assign buf_we_w = wr_ok && (wb_adr[11:8] == 4'h1);
    assign buf_adr  = wb_adr[`CONV_BUF_AW-1:0];
    assign buf_dat  = wb_dat_w;

    ////////////////////////////////////////
    // bus side

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= acc_cyc;   // zero wait states
        end
    end

    always_ff @(posedge clk) begin
        if (acc_cyc && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

    always_comb begin
        rd_mux = '0;
        case (wb_adr) inside
            12'h200: rd_mux[1] = cfg.mode;
            12'h201: begin
                rd_mux[4:0]   = cfg.ix;
                rd_mux[12:8]  = cfg.iy;
                rd_mux[17:16] = cfg.k;
                rd_mux[21:20] = cfg.s;
                rd_mux[26:24] = cfg.nif_words;
            end
            [12'h210:12'h213]: rd_mux[`CONV_BIAS_W-1:0] = cfg.bias[wb_adr[1:0]];
            [12'h220:12'h223]: rd_mux[`CONV_TAIL_W-1:0] = cfg.tail[wb_adr[1:0]];
            [12'h230:12'h233]: rd_mux[`CONV_RANK_W-1:0] = cfg.rank[wb_adr[1:0]];
            12'h240: rd_mux[1:0] = {done, busy};
            default: rd_mux = '0;   // buffers read as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_ok) begin
                case (wb_adr) inside
                    12'h200: begin
                        cfg.mode <= wb_dat_w[1];
                        start    <= wb_dat_w[0];
                    end
                    12'h201: begin
                        cfg.ix        <= wb_dat_w[4:0];
                        cfg.iy        <= wb_dat_w[12:8];
                        cfg.k         <= wb_dat_w[17:16];
                        cfg.s         <= wb_dat_w[21:20];
                        cfg.nif_words <= wb_dat_w[26:24];
                    end
                    [12'h210:12'h213]: cfg.bias[wb_adr[1:0]] <= wb_dat_w[`CONV_BIAS_W-1:0];
                    [12'h220:12'h223]: cfg.tail[wb_adr[1:0]] <= wb_dat_w[`CONV_TAIL_W-1:0];
                    [12'h230:12'h233]: cfg.rank[wb_adr[1:0]] <= wb_dat_w[`CONV_RANK_W-1:0];
                    default: start <= 1'b0;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // busy / done tracking

    assign sh      = (cfg.s == 2'd2);
    assign ox_last = (cfg.ix - cfg.k) >> sh;
    assign oy_last = (cfg.iy - cfg.k) >> sh;
    assign n_out   = (ox_last + 1'b1) * (oy_last + 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            walk_done <= 1'b0;
            pending   <= '0;
        end else if (start) begin
            busy      <= 1'b1;
            done      <= 1'b0;
            walk_done <= 1'b0;
            pending   <= n_out;
        end else if (busy) begin
            if (out_valid) begin
                pending <= pending - 1'b1;
            end
            if (tile_done) begin
                walk_done <= 1'b1;
            end
            // last request issued and every result has left
            if (walk_done && (pending == '0)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_buffers.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_buffers import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    we_f,
    input  logic                    we_w,
    input  logic [`CONV_BUF_AW-1:0] adr,
    input  logic [`CONV_WORD_W-1:0] dat,
    input  rd_req_t                 req,
    output logic [`CONV_WORD_W-1:0] f_word,
    output weight_word_u            w_word,
    output rd_req_t                 req_q
);

    logic [`CONV_WORD_W-1:0] fmap [`CONV_FMAP_DEPTH];
    weight_word_u            wmap [`CONV_WMAP_DEPTH];

    ////////////////////////////////////////
    // feature RAM

    always_ff @(posedge clk) begin
        if (we_f) begin
            fmap[adr] <= dat;
        end
        f_word <= fmap[req.f_adr];
    end

    ////////////////////////////////////////
    // weight RAM

    always_ff @(posedge clk) begin
        if (we_w) begin
            wmap[adr] <= dat;   // raw word, decoded later by mode
        end
        w_word <= wmap[req.w_adr];
    end

    // tags travel with the read data
    always_ff @(posedge clk) begin
        req_q <= req;
    end

endmodule

`default_nettype wire

// File: hw/conv_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_addr_gen import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  conv_cfg_t cfg,
    input  logic      start,
    output rd_req_t   req,
    output logic      tile_done
);

    logic                   running;
    logic [`CONV_DIM_W-1:0] ox;         // output pixel position
    logic [`CONV_DIM_W-1:0] oy;
    logic [1:0]             kx;
    logic [1:0]             ky;
    logic [1:0]             word;       // feature word within a pixel
    logic [1:0]             lane;       // mode 0 only
    logic                   sh;
    logic [`CONV_DIM_W-1:0] ox_last;
    logic [`CONV_DIM_W-1:0] oy_last;
    logic                   lane_end;
    logic                   word_end;
    logic                   kx_end;
    logic                   ky_end;
    logic                   ox_end;
    logic                   oy_end;
    logic [`CONV_DIM_W:0]   px;         // input pixel under the tap
    logic [`CONV_DIM_W:0]   py;
    logic [15:0]            f_lin;
    logic [15:0]            tap;
    logic [15:0]            w_lin;

    assign sh      = (cfg.s == 2'd2);
    assign ox_last = (cfg.ix - cfg.k) >> sh;
    assign oy_last = (cfg.iy - cfg.k) >> sh;

    assign lane_end = cfg.mode || (lane == 2'd3);   // mode 1 takes all lanes at once
    assign word_end = ({1'b0, word} == cfg.nif_words - 3'd1);
    assign kx_end   = (kx == cfg.k - 2'd1);
    assign ky_end   = (ky == cfg.k - 2'd1);
    assign ox_end   = (ox == ox_last);
    assign oy_end   = (oy == oy_last);

    ////////////////////////////////////////
    // address math

    assign px    = ({1'b0, ox} << sh) + kx;
    assign py    = ({1'b0, oy} << sh) + ky;
    assign f_lin = (py * cfg.ix + px) * cfg.nif_words + word;
    assign tap   = ky * cfg.k + kx;
    assign w_lin = tap * cfg.nif_words + word;

    always_comb begin
        req.valid = running;
        req.f_adr = f_lin[`CONV_BUF_AW-1:0];
        req.w_adr = cfg.mode ? w_lin[`CONV_BUF_AW-1:0] : {w_lin[`CONV_BUF_AW-3:0], lane};
        req.lane  = lane;
        req.first = (ky == 2'd0) && (kx == 2'd0) && (word == 2'd0) && (lane == 2'd0);
        req.last  = lane_end && word_end && kx_end && ky_end;
    end

    ////////////////////////////////////////
    // loop nest, lane innermost

    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            tile_done <= 1'b0;
            {oy, ox, ky, kx, word, lane} <= '0;
        end else begin
            tile_done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                {oy, ox, ky, kx, word, lane} <= '0;
            end else if (running) begin
                lane <= lane_end ? 2'd0 : lane + 2'd1;
                if (lane_end) begin
                    word <= word_end ? 2'd0 : word + 2'd1;
                    if (word_end) begin
                        kx <= kx_end ? 2'd0 : kx + 2'd1;
                        if (kx_end) begin
                            ky <= ky_end ? 2'd0 : ky + 2'd1;
                            if (ky_end) begin
                                ox <= ox_end ? '0 : ox + 1'b1;
                                if (ox_end) begin
                                    oy <= oy_end ? '0 : oy + 1'b1;
                                    if (oy_end) begin
                                        running   <= 1'b0;   // tile walked
                                        tile_done <= 1'b1;
                                    end
                                end
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_pe_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_pe_array import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mode,
    input  logic [`CONV_WORD_W-1:0] f_word,
    input  weight_word_u            w_word,
    input  rd_req_t                 req_q,
    output acc_t [`CONV_OCH-1:0]    acc,
    output logic                    acc_valid
);

    logic [`CONV_LANES-1:0][`CONV_PIX_W-1:0] pix;   // unsigned pixels
    acc_t [`CONV_OCH-1:0]                    term;

    assign pix = f_word;

    ////////////////////////////////////////
    // per-channel product term

    always_comb begin
        for (int c = 0; c < `CONV_OCH; c++) begin
            term[c] = '0;
            if (!mode) begin
                // one lane, 8-bit signed weight
                term[c] = $signed({1'b0, pix[req_q.lane]}) * w_word.w8[c];
            end else begin
                for (int l = 0; l < `CONV_LANES; l++) begin
                    case (w_word.w2[c][l])
                        2'b01:   term[c] = term[c] + $signed({1'b0, pix[l]});
                        2'b11:   term[c] = term[c] - $signed({1'b0, pix[l]});
                        default: term[c] = term[c];   // 00 and 10 are zero
                    endcase
                end
            end
        end
    end

    ////////////////////////////////////////
    // accumulators

    always_ff @(posedge clk) begin
        if (req_q.valid) begin
            for (int c = 0; c < `CONV_OCH; c++) begin
                acc[c] <= req_q.first ? term[c] : acc[c] + term[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= req_q.valid && req_q.last;   // acc holds the full sum now
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_requant.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_requant import conv_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  conv_cfg_t            cfg,
    input  acc_t [`CONV_OCH-1:0] acc,
    input  logic                 acc_valid,
    output conv_out_t            out
);

    localparam int SUM_W  = `CONV_ACC_W + 1;
    localparam int PROD_W = SUM_W + `CONV_TAIL_W + 1;
    localparam logic signed [PROD_W-1:0] SAT_HI = 127;
    localparam logic signed [PROD_W-1:0] SAT_LO = -128;

    logic                     s1_valid;
    logic signed [SUM_W-1:0]  s1_sum [`CONV_OCH];
    logic signed [PROD_W-1:0] scaled [`CONV_OCH];
    logic                     out_valid_q;
    sbyte_t [`CONV_OCH-1:0]   out_data_q;

    ////////////////////////////////////////
    // stage 1, bias add

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            for (int c = 0; c < `CONV_OCH; c++) begin
                s1_sum[c] <= acc[c] + $signed(cfg.bias[c]);
            end
        end
    end

    ////////////////////////////////////////
    // stage 2, scale, shift and clip

    always_comb begin
        for (int c = 0; c < `CONV_OCH; c++) begin
            // tail is unsigned, shift keeps the sign
            scaled[c] = (s1_sum[c] * $signed({1'b0, cfg.tail[c]})) >>> cfg.rank[c];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int c = 0; c < `CONV_OCH; c++) begin
                if (scaled[c] > SAT_HI) begin
                    out_data_q[c] <= 8'h7f;
                end else if (scaled[c] < SAT_LO) begin
                    out_data_q[c] <= 8'h80;
                end else begin
                    out_data_q[c] <= scaled[c][`CONV_PIX_W-1:0];
                end
            end
        end
    end

    assign out = '{valid: out_valid_q, data: out_data_q};

endmodule

`default_nettype wire

// File: hw/conv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_datapath import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`CONV_WB_AW-1:0]  wb_adr,
    input  logic [`CONV_WORD_W-1:0] wb_dat_w,
    output logic [`CONV_WORD_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    output conv_out_t               out
);

    // host write port into the buffers
    logic                    buf_we_f;
    logic                    buf_we_w;
    logic [`CONV_BUF_AW-1:0] buf_adr;
    logic [`CONV_WORD_W-1:0] buf_dat;

    conv_cfg_t               cfg;
    logic                    start;
    logic                    tile_done;
    rd_req_t                 req;
    rd_req_t                 req_q;
    logic [`CONV_WORD_W-1:0] f_word;
    weight_word_u            w_word;
    acc_t [`CONV_OCH-1:0]    acc;
    logic                    acc_valid;

    conv_cfg_regs i_cfg (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .buf_we_f, .buf_we_w, .buf_adr, .buf_dat,
        .cfg, .start, .tile_done,
        .out_valid (out.valid)
    );

    conv_buffers i_buf (
        .clk,
        .we_f (buf_we_f), .we_w (buf_we_w), .adr (buf_adr), .dat (buf_dat),
        .req, .f_word, .w_word, .req_q
    );

    conv_addr_gen i_agen (.clk, .rst, .cfg, .start, .req, .tile_done);

    conv_pe_array i_pe (
        .clk, .rst, .mode (cfg.mode),
        .f_word, .w_word, .req_q, .acc, .acc_valid
    );

    conv_requant i_rq (.clk, .rst, .cfg, .acc, .acc_valid, .out);

endmodule

`default_nettype wire

// File: verif/conv_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb_clk #(
    parameter int HALF_NS = 50   // 100 ns period
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

// File: verif/conv_datapath_assert.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath_assert import conv_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      wb_cyc,
    input logic      wb_stb,
    input logic      wb_ack,
    input conv_out_t out
);

    ////////////////////////////////////////
    // Wishbone slave side

    // ack answers a request seen one cycle earlier
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding cyc and stb");

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)   // single pulse, no bursts
        else $error("wb_ack high for two cycles in a row");

    ////////////////////////////////////////
    // result stream

    no_out_in_reset: assert property (@(posedge clk) rst |=> !out.valid)
        else $error("out.valid asserted while in reset");

endmodule

bind conv_datapath conv_datapath_assert i_assert (.clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .out);

`default_nettype wire

// File: verif/conv_datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_datapath_tb import conv_pkg::*; ();

    localparam int BUS_CYC  = 2;    // cycles per bus access
    localparam int POLL_CYC = 24;   // pipeline drain and last status poll
    // cycle estimates per test at the largest random sizes
    localparam int T1_CYC = 40 * BUS_CYC;
    localparam int T2_CYC = (144 + 144 + 16) * BUS_CYC + 16 * 9 * 4 * 4 + POLL_CYC;
    localparam int T3_CYC = 2 * ((256 + 17 + 16) * BUS_CYC + 16 * 4 * 4 + POLL_CYC);
    localparam int T4_CYC = (16 + 2 + 16) * BUS_CYC + 16 + POLL_CYC;
    localparam int T5_CYC = (32 + 32 + 20) * BUS_CYC + 2 * (9 * 2 * 2 * 2 * 4 + POLL_CYC);
    localparam int LIMIT_CYC = (3 + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC) * 3 / 2;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`CONV_WB_AW-1:0]  wb_adr;
    logic [`CONV_WORD_W-1:0] wb_dat_w;
    logic [`CONV_WORD_W-1:0] wb_dat_r;
    logic                    wb_ack;
    conv_out_t               dut_out;

    integer    seed = 40;
    int        errors;
    int        checks;
    int        test_errs;
    conv_cfg_t cfg_m;                           // config as the model sees it
    logic [31:0] fmem [`CONV_FMAP_DEPTH];      // buffer images
    logic [31:0] wmem [`CONV_WMAP_DEPTH];
    conv_out_t exp_q [$];
    conv_out_t got_q [$];

    conv_tb_clk i_clk (.clk);

    conv_datapath i_dut (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .out (dut_out)
    );

    // result stream has no ready so every word is taken here
    always @(negedge clk) begin
        if (dut_out.valid) begin
            got_q.push_back(dut_out);
        end
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout: run did not end within %0d clock cycles", LIMIT_CYC);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////
    // compare and helpers

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_out(input int idx, input conv_out_t got, input conv_out_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: output %0d got %h expected %h",
                     $time, idx, got.data, exp.data);
            errors++;
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic finish_test(input int num, input string name);
        $display("test %0d  %-26s %s", num, name, (errors == test_errs) ? "ok" : "FAILED");
        test_errs = errors;
    endtask

    ////////////////////////////////////////
    // bus master driving 1 ns after the edge

    task automatic bus_access(input logic we, input logic [11:0] adr,
                              input logic [31:0] dat);
        int n;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            $display("bus error at %0t: no ack for address %h", $time, adr);
            errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] dat);
        bus_access(1'b1, adr, dat);
    endtask

    task automatic bus_read(input logic [11:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, '0);
        dat = wb_dat_r;   // registered with the ack
    endtask

    task automatic readback_reg(input logic [11:0] adr, input logic [31:0] mask);
        logic [31:0] wd;
        logic [31:0] rd;
        wd = $random(seed);
        if (adr == 12'h200) begin
            wd[0] = 1'b0;   // keep the engine idle
        end
        bus_write(adr, wd);
        bus_read(adr, rd);
        check_word($sformatf("register %h", adr), rd, wd & mask);
    endtask

    ////////////////////////////////////////
    // setup of a tile

    task automatic load_buffers(input int nf, input int nw);
        for (int i = 0; i < nf; i++) begin
            fmem[i] = $random(seed);
            bus_write(12'h000 + i, fmem[i]);
        end
        for (int i = 0; i < nw; i++) begin
            wmem[i] = $random(seed);
            bus_write(12'h100 + i, wmem[i]);
        end
    endtask

    task automatic set_requant(input int rank_lo, input int rank_hi);
        for (int c = 0; c < `CONV_OCH; c++) begin
            cfg_m.bias[c] = 16'(rand_range(-512, 511));
            cfg_m.tail[c] = 16'(rand_range(1, 255));
            cfg_m.rank[c] = 5'(rand_range(rank_lo, rank_hi));
        end
    endtask

    task automatic write_config();
        bus_write(12'h201, {5'b0, cfg_m.nif_words, 2'b0, cfg_m.s, 2'b0, cfg_m.k,
                            3'b0, cfg_m.iy, 3'b0, cfg_m.ix});
        for (int c = 0; c < `CONV_OCH; c++) begin
            bus_write(12'h210 + c, {16'b0, cfg_m.bias[c]});
            bus_write(12'h220 + c, {16'b0, cfg_m.tail[c]});
            bus_write(12'h230 + c, {27'b0, cfg_m.rank[c]});
        end
    endtask

    ////////////////////////////////////////
    // reference model

    task automatic build_expected();
        int ix;
        int k;
        int s;
        int nif;
        int ox_n;
        int oy_n;
        int fa;
        int wa;
        int pix;
        int sum [`CONV_OCH];
        longint scaled;
        logic [1:0] code;
        conv_out_t e;
        ix   = cfg_m.ix;
        k    = cfg_m.k;
        s    = cfg_m.s;
        nif  = cfg_m.nif_words;
        ox_n = (ix - k) / s + 1;
        oy_n = (int'(cfg_m.iy) - k) / s + 1;
        exp_q.delete();
        for (int oy = 0; oy < oy_n; oy++) begin
            for (int ox = 0; ox < ox_n; ox++) begin   // raster order
                foreach (sum[c]) begin
                    sum[c] = 0;
                end
                for (int ky = 0; ky < k; ky++) begin
                    for (int kx = 0; kx < k; kx++) begin
                        for (int wd = 0; wd < nif; wd++) begin
                            fa = ((oy * s + ky) * ix + ox * s + kx) * nif + wd;
                            for (int l = 0; l < `CONV_LANES; l++) begin
                                pix = fmem[fa][8*l +: 8];   // unsigned pixel
                                for (int c = 0; c < `CONV_OCH; c++) begin
                                    if (cfg_m.mode == 1'b0) begin
                                        wa = ((ky * k + kx) * nif + wd) * 4 + l;
                                        sum[c] += pix * int'($signed(wmem[wa][8*c +: 8]));
                                    end else begin
                                        wa = (ky * k + kx) * nif + wd;
                                        code = wmem[wa][8*c + 2*l +: 2];
                                        case (code)
                                            2'b01:   sum[c] += pix;
                                            2'b11:   sum[c] -= pix;
                                            default: sum[c] += 0;   // 00 and 10
                                        endcase
                                    end
                                end
                            end
                        end
                    end
                end
                for (int c = 0; c < `CONV_OCH; c++) begin
                    sum[c] += int'($signed(cfg_m.bias[c]));
                    scaled = (longint'(sum[c]) * longint'(cfg_m.tail[c])) >>> cfg_m.rank[c];
                    if (scaled > 127) begin
                        e.data[c] = 8'h7f;
                    end else if (scaled < -128) begin
                        e.data[c] = 8'h80;
                    end else begin
                        e.data[c] = scaled[7:0];
                    end
                end
                e.valid = 1'b1;
                exp_q.push_back(e);
            end
        end
    endtask

    ////////////////////////////////////////
    // run one tile and compare

    task automatic run_tile(input bit protect);
        logic [31:0] st;
        int polls;
        got_q.delete();
        build_expected();
        bus_write(12'h200, {30'b0, cfg_m.mode, 1'b1});
        if (protect) begin
            bus_read(12'h240, st);
            check_word("status while running", st, 32'h1);
            bus_write(12'h000, ~fmem[0]);   // must be dropped
            bus_write(12'h100, ~wmem[0]);
        end
        st    = '0;
        polls = 0;
        while (!st[1] && polls < 4000) begin
            bus_read(12'h240, st);
            polls++;
        end
        if (!st[1]) begin
            $display("engine never reported done at %0t", $time);
            errors++;
        end else begin
            check_word("status at done", st, 32'h2);
        end
        // every result has to be out by the time done shows
        check_word("output count", got_q.size(), exp_q.size());
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_out(i, got_q[i], exp_q[i]);
        end
    endtask

    ////////////////////////////////////////
    // test sequence

    initial begin
        logic [31:0] rd;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        errors    = 0;
        checks    = 0;
        test_errs = 0;
        cfg_m     = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        bus_read(12'h240, rd);
        check_word("status after reset", rd, 32'h0);
        bus_read(12'h005, rd);
        check_word("buffer read", rd, 32'h0);
        readback_reg(12'h200, 32'h0000_0002);
        readback_reg(12'h201, 32'h0733_1f1f);
        for (int c = 0; c < `CONV_OCH; c++) begin
            readback_reg(12'h210 + c, 32'h0000_ffff);
            readback_reg(12'h220 + c, 32'h0000_ffff);
            readback_reg(12'h230 + c, 32'h0000_001f);
        end
        finish_test(1, "register readback");

        cfg_m.ix        = 6;
        cfg_m.iy        = 6;
        cfg_m.k         = 3;
        cfg_m.s         = 1;
        cfg_m.nif_words = 3'(rand_range(1, 4));
        cfg_m.mode      = 1'b0;
        set_requant(16, 20);
        load_buffers(36 * cfg_m.nif_words, 36 * cfg_m.nif_words);
        write_config();
        run_tile(1'b0);
        check_word("mode 0 tile size", got_q.size(), 16);
        finish_test(2, "mode 0 k3 s1");

        for (int kk = 1; kk <= 2; kk++) begin
            cfg_m.ix        = 5'(rand_range(4, 8));
            cfg_m.iy        = 5'(rand_range(4, 8));
            cfg_m.k         = 2'(kk);
            cfg_m.s         = 2;
            cfg_m.nif_words = 3'(rand_range(1, 4));
            cfg_m.mode      = 1'b1;
            set_requant(6, 10);
            load_buffers(cfg_m.ix * cfg_m.iy * cfg_m.nif_words, kk * kk * cfg_m.nif_words);
            wmem[0][3:2] = 2'b10;   // code 10 reads as zero
            bus_write(12'h100, wmem[0]);
            write_config();
            run_tile(1'b0);
        end
        finish_test(3, "mode 1 ternary s2");

        cfg_m.ix        = 4;
        cfg_m.iy        = 4;
        cfg_m.k         = 1;
        cfg_m.s         = 1;
        cfg_m.nif_words = 1;
        cfg_m.mode      = 1'b1;
        for (int c = 0; c < `CONV_OCH; c++) begin
            cfg_m.bias[c] = '0;
            cfg_m.tail[c] = 16'hffff;
            cfg_m.rank[c] = '0;
        end
        load_buffers(16, 1);
        wmem[0] = {8'($random(seed)), 8'h1d, 8'hff, 8'h55};   // all +1, all -1, mixed
        bus_write(12'h100, wmem[0]);
        write_config();
        run_tile(1'b0);
        finish_test(4, "saturation");

        cfg_m.ix        = 4;
        cfg_m.iy        = 4;
        cfg_m.k         = 2;
        cfg_m.s         = 1;
        cfg_m.nif_words = 2;
        cfg_m.mode      = 1'b0;
        set_requant(14, 18);
        load_buffers(32, 32);
        write_config();
        run_tile(1'b1);
        run_tile(1'b0);   // same buffers give the same results
        finish_test(5, "done and write protection");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hw/conv_pkg.sv
hw/conv_cfg_regs.sv
hw/conv_buffers.sv
hw/conv_addr_gen.sv
hw/conv_pe_array.sv
hw/conv_requant.sv
hw/conv_datapath.sv
verif/conv_tb_clk.sv
verif/conv_datapath_assert.sv
verif/conv_datapath_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the conv tile testbench, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module conv_datapath_tb -o conv_sim > sim.log 2>&1 &&
./obj_dir/conv_sim >> sim.log 2>&1 ||
echo "build or run did not complete" >> sim.log

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
